/* vlog.f */
+incdir+hw
hw/rv32i_pkg.sv
hw/regfile.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/datapath.sv
testbench/datapath_chk.sv
testbench/tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_datapath -f vlog.f -o tb_datapath

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/tb_datapath +verilator+error+limit+1000 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* testbench/tb_datapath.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module tb_datapath;

    // one expected store, tagged with the behavior it belongs to
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0]  grp;
    } store_exp_t;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk_i;
    logic                 rst_i;
    rv32i_pkg::rv32i_word instr_mem_rdata_i;
    rv32i_pkg::rv32i_word data_mem_rdata_i;
    rv32i_pkg::rv32i_word instr_mem_address_o;
    rv32i_pkg::rv32i_word data_mem_address_o;
    rv32i_pkg::rv32i_word data_mem_wdata_o;
    logic                 data_read_o;
    logic                 data_write_o;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:1023];
    store_exp_t  exp_q [$];
    store_exp_t  cur;
    int          slot;
    logic [31:0] st_addr;
    logic [11:0] lw_off;
    logic [31:0] lw_word;
    logic [31:0] fill_word;
    int          grp_stores [0:7];
    int          grp_errs [0:7];
    int          errors;
    int          cycles;
    int          total;

    datapath UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // memories answer in the same cycle
    assign instr_mem_rdata_i = (instr_mem_address_o < 32'd1024) ?
                               imem[instr_mem_address_o[9:2]] : 32'h0;
    assign data_mem_rdata_i  = dmem[data_mem_address_o[11:2]];

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // sw rs2, imm(x0)
    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    // two zero words after each instruction keep producers three slots ahead
    task automatic put_instr(input logic [31:0] word);
        imem[slot]     = word;
        imem[slot + 1] = 32'h0;
        imem[slot + 2] = 32'h0;
        slot           = slot + 3;
    endtask

    // run one instruction, then store its rd at the next result address
    task automatic calc_store(input logic [31:0] word, input logic [4:0] rd,
                              input logic [31:0] value, input logic [2:0] grp);
        put_instr(word);
        put_instr(enc_sw(st_addr[11:0], rd));
        exp_q.push_back('{addr: st_addr, data: value, grp: grp});
        st_addr = st_addr + 32'd4;
    endtask

    // compare every data write with the next expected store
    always @(posedge clk_i) begin
        if (!rst_i && data_write_o) begin
            if (exp_q.size() == 0) begin
                $display("%0t: store to %h with no store left in the program",
                         $time, data_mem_address_o);
                errors++;
            end else begin
                cur = exp_q.pop_front();
                grp_stores[cur.grp]++;
                assert (data_mem_address_o == cur.addr) else begin
                    $display("[FAIL] %0t data_mem_address_o got %h expected %h",
                             $time, data_mem_address_o, cur.addr);
                    grp_errs[cur.grp]++;
                end
                assert (data_mem_wdata_o == cur.data) else begin
                    $display("[FAIL] %0t data_mem_wdata_o got %h expected %h",
                             $time, data_mem_wdata_o, cur.data);
                    grp_errs[cur.grp]++;
                end
            end
            dmem[data_mem_address_o[11:2]] <= data_mem_wdata_o;
        end
    end

    initial begin
        rst_i   = 1'b1;
        errors  = 0;
        slot    = 0;
        st_addr = 32'h400;
        lw_word = 32'h0;
        for (int g = 0; g < 8; g++) begin
            grp_stores[g] = 0;
            grp_errs[g]   = 0;
        end
        void'($urandom(32'h6ffb_1811));
        lw_off = 12'h600 + 12'(($urandom % 64) * 4);
        // random preload, keep the word the load will read
        for (int i = 0; i < 1024; i++) begin
            fill_word = $urandom;
            dmem[i] <= fill_word;
            if (i == int'(lw_off[11:2])) begin
                lw_word = fill_word;
            end
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end

        // immediate ops, lui, auipc
        calc_store(enc_i(12'hFFB, 0, 3'b000, 1, `OP_IMM), 1, 32'hFFFF_FFFB, 4);
        calc_store(enc_i(12'h402, 1, 3'b101, 2, `OP_IMM), 2, 32'hFFFF_FFFE, 4);
        calc_store(enc_i(12'h01C, 1, 3'b101, 3, `OP_IMM), 3, 32'h0000_000F, 4);
        calc_store(enc_i(12'hFFD, 1, 3'b010, 4, `OP_IMM), 4, 32'h0000_0001, 4);
        calc_store(enc_i(12'h005, 1, 3'b011, 5, `OP_IMM), 5, 32'h0000_0000, 4);
        calc_store(enc_i(12'h0F0, 1, 3'b111, 6, `OP_IMM), 6, 32'h0000_00F0, 4);
        calc_store(enc_i(12'h123, 0, 3'b110, 7, `OP_IMM), 7, 32'h0000_0123, 4);
        calc_store(enc_i(12'hFFF, 1, 3'b100, 8, `OP_IMM), 8, 32'h0000_0004, 4);
        calc_store(enc_i(12'h004, 1, 3'b001, 9, `OP_IMM), 9, 32'hFFFF_FFB0, 4);
        calc_store(enc_u(20'hABCDE, 10, `OP_LUI), 10, 32'hABCD_E000, 4);
        calc_store(enc_u(20'h00001, 11, `OP_AUIPC), 11, 32'(slot * 4) + 32'h1000, 4);

        // register-register ops and a write to x0
        calc_store(enc_r(7'h00, 7, 1, 3'b000, 12), 12, 32'h0000_011E, 5);
        calc_store(enc_r(7'h20, 1, 7, 3'b000, 13), 13, 32'h0000_0128, 5);
        calc_store(enc_r(7'h00, 7, 1, 3'b010, 14), 14, 32'h0000_0001, 5);
        calc_store(enc_r(7'h00, 7, 1, 3'b011, 15), 15, 32'h0000_0000, 5);
        calc_store(enc_r(7'h00, 7, 1, 3'b111, 16), 16, 32'h0000_0123, 5);
        calc_store(enc_r(7'h00, 7, 6, 3'b110, 17), 17, 32'h0000_01F3, 5);
        calc_store(enc_r(7'h00, 7, 1, 3'b100, 18), 18, 32'hFFFF_FED8, 5);
        calc_store(enc_r(7'h00, 4, 7, 3'b001, 21), 21, 32'h0000_0246, 5);
        calc_store(enc_r(7'h00, 3, 1, 3'b101, 22), 22, 32'h0001_FFFF, 5);
        calc_store(enc_r(7'h20, 3, 1, 3'b101, 23), 23, 32'hFFFF_FFFF, 5);
        calc_store(enc_r(7'h00, 7, 1, 3'b000, 0), 0, 32'h0000_0000, 5);

        // load from a random preloaded word, then use it in writeback
        calc_store(enc_i(lw_off, 0, 3'b010, 19, `OP_LOAD), 19, lw_word, 6);
        calc_store(enc_r(7'h00, 7, 19, 3'b000, 20), 20, lw_word + 32'h123, 6);

        repeat (10) @(posedge clk_i);
        #1 rst_i = 1'b0;

        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: program did not finish, %0d stores never seen", exp_q.size());
            errors++;
        end
        repeat (5) @(posedge clk_i);

        $display("behavior 4 immediate ops: %0d stores, %0d errors", grp_stores[4], grp_errs[4]);
        $display("behavior 5 register ops: %0d stores, %0d errors", grp_stores[5], grp_errs[5]);
        $display("behavior 6 load and reuse: %0d stores, %0d errors", grp_stores[6], grp_errs[6]);
        $display("behaviors 1-3 timing checks: %0d errors", UUT.u_chk.err_count);
        total = errors + grp_errs[4] + grp_errs[5] + grp_errs[6] + int'(UUT.u_chk.err_count);
        $display("summary: %0d stores checked, %0d errors",
                 grp_stores[4] + grp_stores[5] + grp_stores[6], total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/datapath_chk.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module datapath_chk (
    input logic                 clk_i,
    input logic                 rst_i,
    input rv32i_pkg::rv32i_word instr_mem_rdata_i,
    input rv32i_pkg::rv32i_word instr_mem_address_o,
    input logic                 data_read_o,
    input logic                 data_write_o
);

    // count of failed assertions
    int unsigned err_count = 0;

    // pc back at the reset address one cycle after a reset edge
    reset_pc: assert property (@(posedge clk_i) rst_i |=> (instr_mem_address_o == `PC_RESET))
        else begin
            err_count++;
            $error("pc not at reset address after reset");
        end

    // cleared ex/mem record means no memory strobe
    reset_strobes: assert property (@(posedge clk_i) rst_i |=> (!data_read_o && !data_write_o))
        else begin
            err_count++;
            $error("data strobe active right after reset");
        end

    // one word per cycle, no branches
    pc_step: assert property (@(posedge clk_i) disable iff (rst_i)
        1'b1 |=> (instr_mem_address_o == $past(instr_mem_address_o) + `PC_STEP))
        else begin
            err_count++;
            $error("pc did not advance by one word");
        end

    strobes_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(data_read_o && data_write_o))
        else begin
            err_count++;
            $error("read and write strobes high together");
        end

    // fetch at n, memory stage at n+3
    store_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        data_write_o == ($past(instr_mem_rdata_i[6:0], 3) == `OP_STORE))
        else begin
            err_count++;
            $error("write strobe not three cycles after a store fetch");
        end

    load_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        data_read_o == ($past(instr_mem_rdata_i[6:0], 3) == `OP_LOAD))
        else begin
            err_count++;
            $error("read strobe not three cycles after a load fetch");
        end

endmodule

bind datapath datapath_chk u_chk (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .instr_mem_rdata_i   (instr_mem_rdata_i),
    .instr_mem_address_o (instr_mem_address_o),
    .data_read_o         (data_read_o),
    .data_write_o        (data_write_o)
);

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv32i_pkg::rv32i_word instr_mem_rdata_i,
    input  rv32i_pkg::rv32i_word data_mem_rdata_i,
    output rv32i_pkg::rv32i_word instr_mem_address_o,
    output rv32i_pkg::rv32i_word data_mem_address_o,
    output rv32i_pkg::rv32i_word data_mem_wdata_o,
    output logic                 data_read_o,
    output logic                 data_write_o
);

    // stage records, each driven by the stage before
    rv32i_pkg::if_id_t    if_id;
    rv32i_pkg::id_ex_t    id_ex;
    rv32i_pkg::ex_mem_t   ex_mem;
    rv32i_pkg::mem_wb_t   mem_wb;

    // writeback into the register file
    logic                 wb_we;
    rv32i_pkg::reg_addr_t wb_rd;
    rv32i_pkg::rv32i_word wb_data;

    fetch_stage u_fetch (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .instr_mem_address_o (instr_mem_address_o),
        .if_id_o             (if_id)
    );

    decode_stage u_decode (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .if_id_i   (if_id),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .id_ex_o   (id_ex)
    );

    execute_stage u_execute (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex),
        .ex_mem_o (ex_mem)
    );

    memory_stage u_memory (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .ex_mem_i           (ex_mem),
        .data_mem_rdata_i   (data_mem_rdata_i),
        .data_mem_address_o (data_mem_address_o),
        .data_mem_wdata_o   (data_mem_wdata_o),
        .data_read_o        (data_read_o),
        .data_write_o       (data_write_o),
        .mem_wb_o           (mem_wb)
    );

    // wb stage: load data or alu result
    assign wb_we   = mem_wb.reg_write;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = (mem_wb.wb_sel == rv32i_pkg::WB_LOAD) ? mem_wb.load_data : mem_wb.alu_out;

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv32i_pkg::ex_mem_t   ex_mem_i,
    input  rv32i_pkg::rv32i_word data_mem_rdata_i,
    output rv32i_pkg::rv32i_word data_mem_address_o,
    output rv32i_pkg::rv32i_word data_mem_wdata_o,
    output logic                 data_read_o,
    output logic                 data_write_o,
    output rv32i_pkg::mem_wb_t   mem_wb_o
);

    // dmem ports straight off the ex/mem record
    // alu result is the word address for lw / sw
    assign data_mem_address_o = ex_mem_i.alu_out;
    assign data_mem_wdata_o   = ex_mem_i.rs2_val;
    assign data_read_o        = ex_mem_i.ctrl.mem_read;
    assign data_write_o       = ex_mem_i.ctrl.mem_write;

    // memory/writeback register
    // load data sampled same cycle, dmem reads are combinational
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.reg_write <= ex_mem_i.ctrl.reg_write;
            mem_wb_o.wb_sel    <= ex_mem_i.ctrl.wb_sel;
            mem_wb_o.alu_out   <= ex_mem_i.alu_out;
            mem_wb_o.load_data <= data_mem_rdata_i;
            mem_wb_o.rd        <= ex_mem_i.rd;
        end
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module execute_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  rv32i_pkg::id_ex_t  id_ex_i,
    output rv32i_pkg::ex_mem_t ex_mem_o
);

    rv32i_pkg::rv32i_word op_a;
    rv32i_pkg::rv32i_word op_b;
    rv32i_pkg::rv32i_word alu_out;
    logic [4:0]           shamt;

    // operand muxes
    assign op_a = (id_ex_i.ctrl.alu_a_sel == rv32i_pkg::A_PC) ? id_ex_i.pc : id_ex_i.rs1_val;
    assign op_b = (id_ex_i.ctrl.alu_b_sel == rv32i_pkg::B_IMM) ? id_ex_i.imm : id_ex_i.rs2_val;

    // shift amount from low five bits only
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            rv32i_pkg::ALU_ADD:  alu_out = op_a + op_b;
            rv32i_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv32i_pkg::ALU_SLL:  alu_out = op_a << shamt;
            rv32i_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            // arithmetic shift keeps the sign
            rv32i_pkg::ALU_SRA:  alu_out = rv32i_pkg::rv32i_word'($signed(op_a) >>> shamt);
            // compares give 1 or 0
            rv32i_pkg::ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv32i_pkg::ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv32i_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv32i_pkg::ALU_OR:   alu_out = op_a | op_b;
            rv32i_pkg::ALU_AND:  alu_out = op_a & op_b;
            default:             alu_out = op_a + op_b;
        endcase
    end

    // execute/memory register
    // rs2 goes on as store data
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.ctrl    <= id_ex_i.ctrl;
            ex_mem_o.alu_out <= alu_out;
            ex_mem_o.rs2_val <= id_ex_i.rs2_val;
            ex_mem_o.rd      <= id_ex_i.rd;
        end
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module decode_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv32i_pkg::if_id_t    if_id_i,
    input  logic                 wb_we_i,
    input  rv32i_pkg::reg_addr_t wb_rd_i,
    input  rv32i_pkg::rv32i_word wb_data_i,
    output rv32i_pkg::id_ex_t    id_ex_o
);

    rv32i_pkg::rv32i_instr_t instr;
    rv32i_pkg::ctrl_word_t   ctrl;
    rv32i_pkg::rv32i_word    imm;
    rv32i_pkg::rv32i_word    rs1_val;
    rv32i_pkg::rv32i_word    rs2_val;
    rv32i_pkg::reg_addr_t    rs1_addr;
    logic                    alt;

    // funct3 to alu op, alt picks sub / sra
    function automatic rv32i_pkg::alu_op_e alu_op_of(input logic [2:0] funct3,
                                                     input logic alt_f);
        rv32i_pkg::alu_op_e op;
        case (funct3)
            3'b000: op = alt_f ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
            3'b001: op = rv32i_pkg::ALU_SLL;
            3'b010: op = rv32i_pkg::ALU_SLT;
            3'b011: op = rv32i_pkg::ALU_SLTU;
            3'b100: op = rv32i_pkg::ALU_XOR;
            3'b101: op = alt_f ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
            3'b110: op = rv32i_pkg::ALU_OR;
            default: op = rv32i_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign instr = if_id_i.instr;
    assign alt   = (instr.r.funct7 == `FUNCT7_ALT);

    // lui reads x0, its rs1 bits belong to the immediate
    assign rs1_addr = (instr.r.opcode == `OP_LUI) ? '0 : instr.r.rs1;

    always_comb begin
        // unknown opcode leaves everything inactive
        ctrl = '0;
        imm  = '0;
        case (instr.r.opcode)
            `OP_REG: begin
                ctrl.alu_op    = alu_op_of(instr.r.funct3, alt);
                ctrl.reg_write = 1'b1;
            end
            `OP_IMM: begin
                // only srai uses the alt bit, addi never becomes sub
                ctrl.alu_op    = alu_op_of(instr.i.funct3, alt && (instr.i.funct3 == 3'b101));
                ctrl.alu_b_sel = rv32i_pkg::B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            `OP_LUI, `OP_AUIPC: begin
                // auipc adds to pc, lui to x0
                if (instr.u.opcode == `OP_AUIPC) begin
                    ctrl.alu_a_sel = rv32i_pkg::A_PC;
                end
                ctrl.alu_b_sel = rv32i_pkg::B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = {instr.u.imm, 12'b0};
            end
            `OP_LOAD: begin
                // address = rs1 + i imm
                ctrl.alu_b_sel = rv32i_pkg::B_IMM;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv32i_pkg::WB_LOAD;
                imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            `OP_STORE: begin
                ctrl.alu_b_sel = rv32i_pkg::B_IMM;
                ctrl.mem_write = 1'b1;
                imm            = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (instr.r.rs2),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val)
    );

    // decode/execute register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.ctrl    <= ctrl;
            id_ex_o.pc      <= if_id_i.pc;
            id_ex_o.rs1_val <= rs1_val;
            id_ex_o.rs2_val <= rs2_val;
            id_ex_o.imm     <= imm;
            id_ex_o.rd      <= instr.r.rd;
        end
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module fetch_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv32i_pkg::rv32i_word instr_mem_rdata_i,
    output rv32i_pkg::rv32i_word instr_mem_address_o,
    output rv32i_pkg::if_id_t    if_id_o
);

    rv32i_pkg::rv32i_word pc_q;

    // no branches, so the pc only steps forward
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `PC_RESET;
        end else begin
            pc_q <= pc_q + `PC_STEP;
        end
    end

    // imem answers combinationally on the current pc
    assign instr_mem_address_o = pc_q;

    // fetch/decode register
    // zero instr on reset decodes as a no-op
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            if_id_o <= '0;
        end else begin
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= instr_mem_rdata_i;
        end
    end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module regfile (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 we_i,
    input  rv32i_pkg::reg_addr_t waddr_i,
    input  rv32i_pkg::rv32i_word wdata_i,
    input  rv32i_pkg::reg_addr_t raddr1_i,
    input  rv32i_pkg::reg_addr_t raddr2_i,
    output rv32i_pkg::rv32i_word rdata1_o,
    output rv32i_pkg::rv32i_word rdata2_o
);

    rv32i_pkg::rv32i_word regs [`NUM_REGS];
    logic                 wr_live;

    // x0 never takes a write
    assign wr_live = we_i && (waddr_i != '0);

    // read port with write-through from writeback
    function automatic rv32i_pkg::rv32i_word read_port(input rv32i_pkg::reg_addr_t raddr);
        if (wr_live && (waddr_i == raddr)) begin
            return wdata_i;
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // re-evaluated on any change of the array or the write port
    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

/* hw/rv32i_pkg.sv */
`include "rv32i_defines.svh"

package rv32i_pkg;

    // data and address word
    typedef logic [`XLEN-1:0] rv32i_word;
    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    // immediate, load and shift-immediate format
    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    // store format, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // lui / auipc format
    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one instruction word, four views
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } rv32i_instr_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic {A_RS1 = 1'b0, A_PC = 1'b1} alu_a_sel_e;
    typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} alu_b_sel_e;
    typedef enum logic {WB_ALU = 1'b0, WB_LOAD = 1'b1} wb_sel_e;

    // all zero is a no-op
    typedef struct packed {
        alu_op_e    alu_op;
        alu_a_sel_e alu_a_sel;
        alu_b_sel_e alu_b_sel;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        wb_sel_e    wb_sel;
    } ctrl_word_t;

    typedef struct packed {
        rv32i_word    pc;
        rv32i_instr_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  rs1_val;
        rv32i_word  rs2_val;
        rv32i_word  imm;
        reg_addr_t  rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  alu_out;
        rv32i_word  rs2_val;
        reg_addr_t  rd;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        wb_sel_e   wb_sel;
        rv32i_word alu_out;
        rv32i_word load_data;
        reg_addr_t rd;
    } mem_wb_t;

endpackage

/* hw/rv32i_defines.svh */
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// datapath word and register index widths
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// first fetch address, then one word per instruction
`define PC_RESET    32'h0000_0000
`define PC_STEP     32'd4

// major opcodes, bits [6:0] of the instruction
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

// funct7 selecting sub / sra / srai
`define FUNCT7_ALT  7'b0100000

`endif
